/* source/motor_cfg_pkg.sv */
package motor_cfg_pkg;

  ////////////////////////////////////////
  // datapath widths
  ////////////////////////////////////////
  localparam int PWM_W      = 11;   // pwm window counter, 2048 clocks
  localparam int NUM_GATES  = 6;    // hg, lg, hy, ly, hb, lb
  localparam int COIL_W     = 13;   // signed coil voltage / torque
  localparam int OMEGA_W    = 20;   // signed angular velocity
  localparam int THETA_W    = 15;   // angular position, degrees * 64
  localparam int THETA_FRAC = 6;    // fraction bits of a degree in theta

  // gate drive
  localparam logic [PWM_W-1:0] DUTY_DRIVEN = 11'd1023;  // both below this, end floats

  ////////////////////////////////////////
  // mechanics
  ////////////////////////////////////////
  localparam logic signed [COIL_W-1:0]  FRICTION       = 13'sh070;
  localparam logic signed [OMEGA_W-1:0] OMEGA_STICTION = 20'sh00200;  // rolling threshold

  localparam logic [THETA_W-1:0] THETA_FULL  = 15'd23040;  // 360 * 64
  localparam logic [THETA_W-1:0] THETA_RESET = 15'd1920;   // 30 deg, mid green rise
  localparam int                 SECTOR_DEG  = 60;         // one hall sector in degrees

  ////////////////////////////////////////
  // current filter
  ////////////////////////////////////////
  localparam int CURR_FILTER_SH = 5;    // filter weight denominator is 2**5
  localparam int CURR_ACC_W     = 17;   // accumulator, avg_curr is its upper part
  localparam int CURR_SPD_SH    = 9;    // speed scale denominator is 2**9

  localparam logic [CURR_FILTER_SH-1:0] CURR_FILTER_K  = 5'd31;   // 31/32 feedback
  localparam logic [11:0]               CURR_SPD_UNITY = 12'd512; // 1.0 in speed scale

endpackage

/* source/motor_types_pkg.sv */
package motor_types_pkg;

  // captured high time of one gate over a window
  typedef logic [motor_cfg_pkg::PWM_W-1:0] duty_t;

  // coil pair voltage, also carries torque
  typedef logic signed [motor_cfg_pkg::COIL_W-1:0] coil_v_t;

  // angular velocity and its magnitude
  typedef logic signed [motor_cfg_pkg::OMEGA_W-1:0] omega_t;
  typedef logic [motor_cfg_pkg::OMEGA_W-2:0]        omega_mag_t;

  // angular position, 0 .. THETA_FULL-1
  typedef logic [motor_cfg_pkg::THETA_W-1:0] theta_t;

  // averaged current, top bits of the filter accumulator
  typedef logic [motor_cfg_pkg::CURR_ACC_W-motor_cfg_pkg::CURR_FILTER_SH-1:0] curr_t;

  ////////////////////////////////////////
  // hall sector code {grn, ylw, blu}
  ////////////////////////////////////////
  // listed in forward rotation order
  typedef enum logic [2:0] {
    HALL_G_RISE = 3'b101,   // 0 .. 59 deg
    HALL_G_FALL = 3'b100,   // 60 .. 119
    HALL_Y_RISE = 3'b110,   // 120 .. 179
    HALL_Y_FALL = 3'b010,   // 180 .. 239
    HALL_B_RISE = 3'b011,   // 240 .. 299
    HALL_B_FALL = 3'b001    // 300 .. 359
  } hall_sector_e;

endpackage

/* source/gate_duty_if.sv */
interface gate_duty_if;

  // captured duties, one per gate
  motor_types_pkg::duty_t hg;   // green high side
  motor_types_pkg::duty_t lg;   // green low side
  motor_types_pkg::duty_t hy;   // yellow high side
  motor_types_pkg::duty_t ly;   // yellow low side
  motor_types_pkg::duty_t hb;   // blue high side
  motor_types_pkg::duty_t lb;   // blue low side

  logic vld;                    // one cycle pulse per window, duties new

  // duty measurement side
  modport meter (
    output hg, lg, hy, ly, hb, lb,
    output vld
  );

  // voltage calculation side
  modport user (
    input hg, lg, hy, ly, hb, lb,
    input vld
  );

endinterface

/* source/coil_volt_if.sv */
interface coil_volt_if;

  motor_types_pkg::coil_v_t gy;   // green minus yellow end
  motor_types_pkg::coil_v_t yb;   // yellow minus blue end
  motor_types_pkg::coil_v_t bg;   // blue minus green end

  logic vld;                      // window strobe, passed along with the voltages

  modport calc (
    output gy, yb, bg,
    output vld
  );

  // rotor and current blocks
  modport user (
    input gy, yb, bg,
    input vld
  );

endinterface

/* source/gate_duty_meter.sv */
module gate_duty_meter (
  input  logic              clk,
  input  logic              RST_n,
  input  logic              high_grn,
  input  logic              low_grn,
  input  logic              high_ylw,
  input  logic              low_ylw,
  input  logic              high_blu,
  input  logic              low_blu,
  gate_duty_if.meter        duty
);

  logic [motor_cfg_pkg::PWM_W-1:0]     win_cnt;   // free running window position
  logic                                period_over;
  logic [motor_cfg_pkg::NUM_GATES-1:0] gate;      // gate drives as one vector
  motor_types_pkg::duty_t              cnt [motor_cfg_pkg::NUM_GATES];  // running high time
  motor_types_pkg::duty_t              dty [motor_cfg_pkg::NUM_GATES];  // last window result
  logic                                vld_q;

  // index 5 is green high, index 0 is blue low
  assign gate = {high_grn, low_grn, high_ylw, low_ylw, high_blu, low_blu};

  ////////////////////////////////////////
  // window counter
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge RST_n) begin
    if (!RST_n)
      win_cnt <= '0;
    else
      win_cnt <= win_cnt + 1'b1;  // wraps every 2048 clocks
  end

  assign period_over = &win_cnt;  // last clock of the window

  ////////////////////////////////////////
  // high time counters and capture
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge RST_n) begin
    if (!RST_n) begin
      for (int i = 0; i < motor_cfg_pkg::NUM_GATES; i++) begin
        cnt[i] <= '0;
        dty[i] <= '0;
      end
    end else if (period_over) begin
      for (int i = 0; i < motor_cfg_pkg::NUM_GATES; i++) begin
        dty[i] <= cnt[i];         // latch the finished window
        cnt[i] <= '0;             // and start over
      end
    end else begin
      for (int i = 0; i < motor_cfg_pkg::NUM_GATES; i++) begin
        if (gate[i])
          cnt[i] <= cnt[i] + 1'b1;
      end
    end
  end

  // new duties are readable the cycle after capture
  always_ff @(posedge clk or negedge RST_n) begin
    if (!RST_n)
      vld_q <= 1'b0;
    else
      vld_q <= period_over;
  end

  assign duty.hg  = dty[5];
  assign duty.lg  = dty[4];
  assign duty.hy  = dty[3];
  assign duty.ly  = dty[2];
  assign duty.hb  = dty[1];
  assign duty.lb  = dty[0];
  assign duty.vld = vld_q;

  // the strobe must stay a single pulse for the downstream integrators
  a_vld_pulse: assert property (@(posedge clk) disable iff (!RST_n)
    duty.vld |=> !duty.vld)
    else $error("gate_duty_meter: vld high on two consecutive cycles");

endmodule

/* source/coil_voltage_calc.sv */
module coil_voltage_calc (
  gate_duty_if.user  duty,
  coil_volt_if.calc  coil
);

  logic                     und_g, und_y, und_b;   // end floating, both gates mostly off
  motor_types_pkg::coil_v_t net_g, net_y, net_b;   // net drive of each end

  // high side time minus low side time of one end
  function automatic motor_types_pkg::coil_v_t net_drive(
    input motor_types_pkg::duty_t hi,
    input motor_types_pkg::duty_t lo
  );
    // zero extend 11 bit duties into the 13 bit signed range
    net_drive = $signed({2'b00, hi}) - $signed({2'b00, lo});
  endfunction

  // an end counts as undriven when neither gate reaches half a window
  function automatic logic undriven(
    input motor_types_pkg::duty_t hi,
    input motor_types_pkg::duty_t lo
  );
    undriven = (hi < motor_cfg_pkg::DUTY_DRIVEN) && (lo < motor_cfg_pkg::DUTY_DRIVEN);
  endfunction

  ////////////////////////////////////////
  // per end drive
  ////////////////////////////////////////
  assign net_g = net_drive(duty.hg, duty.lg);
  assign net_y = net_drive(duty.hy, duty.ly);
  assign net_b = net_drive(duty.hb, duty.lb);

  assign und_g = undriven(duty.hg, duty.lg);
  assign und_y = undriven(duty.hy, duty.ly);
  assign und_b = undriven(duty.hb, duty.lb);

  ////////////////////////////////////////
  // coil pair voltages
  ////////////////////////////////////////
  // no current path through a pair with a floating end
  assign coil.gy = (und_g || und_y) ? '0 : net_g - net_y;
  assign coil.yb = (und_y || und_b) ? '0 : net_y - net_b;
  assign coil.bg = (und_b || und_g) ? '0 : net_b - net_g;

  assign coil.vld = duty.vld;   // voltages settle with the duties

endmodule

/* source/rotor_dynamics.sv */
module rotor_dynamics (
  input  logic                        clk,
  input  logic                        RST_n,
  coil_volt_if.user                   coil,
  output logic                        hall_grn,
  output logic                        hall_ylw,
  output logic                        hall_blu,
  output motor_types_pkg::omega_mag_t omega_mag
);

  motor_types_pkg::theta_t       theta;      // angular position
  motor_types_pkg::omega_t       omega;      // angular velocity
  motor_types_pkg::omega_t       d_omega;    // velocity step per window
  logic signed [motor_cfg_pkg::THETA_W:0] new_theta;  // one extra bit for the sign
  logic [8:0]                    pos;        // whole degrees 0 .. 359
  motor_types_pkg::hall_sector_e sector;
  logic [2:0]                    hall_code;
  motor_types_pkg::coil_v_t      fav_v;      // voltage of the pair this sector favors
  motor_types_pkg::coil_v_t      back_emf;
  motor_types_pkg::coil_v_t      raw_torque;
  motor_types_pkg::coil_v_t      net_torque;
  motor_types_pkg::coil_v_t      alpha;      // angular acceleration

  ////////////////////////////////////////
  // sector decode and hall outputs
  ////////////////////////////////////////
  assign pos = theta[motor_cfg_pkg::THETA_W-1:motor_cfg_pkg::THETA_FRAC];

  always_comb begin
    if (pos < motor_cfg_pkg::SECTOR_DEG)
      sector = motor_types_pkg::HALL_G_RISE;
    else if (pos < 2 * motor_cfg_pkg::SECTOR_DEG)
      sector = motor_types_pkg::HALL_G_FALL;
    else if (pos < 3 * motor_cfg_pkg::SECTOR_DEG)
      sector = motor_types_pkg::HALL_Y_RISE;
    else if (pos < 4 * motor_cfg_pkg::SECTOR_DEG)
      sector = motor_types_pkg::HALL_Y_FALL;
    else if (pos < 5 * motor_cfg_pkg::SECTOR_DEG)
      sector = motor_types_pkg::HALL_B_RISE;
    else
      sector = motor_types_pkg::HALL_B_FALL;   // 300 .. 359
  end

  assign hall_code = sector;
  assign {hall_grn, hall_ylw, hall_blu} = hall_code;

  ////////////////////////////////////////
  // torque
  ////////////////////////////////////////
  // falling sectors use the reversed pair, so positive always means forward
  always_comb begin
    case (sector)
      motor_types_pkg::HALL_G_RISE: fav_v = coil.gy;
      motor_types_pkg::HALL_G_FALL: fav_v = -coil.bg;
      motor_types_pkg::HALL_Y_RISE: fav_v = coil.yb;
      motor_types_pkg::HALL_Y_FALL: fav_v = -coil.gy;
      motor_types_pkg::HALL_B_RISE: fav_v = coil.bg;
      motor_types_pkg::HALL_B_FALL: fav_v = -coil.yb;
      default:                      fav_v = '0;
    endcase
  end

  assign omega_mag = omega[motor_cfg_pkg::OMEGA_W-1] ?
                     motor_types_pkg::omega_mag_t'(-omega) :
                     motor_types_pkg::omega_mag_t'(omega);
  assign back_emf  = motor_types_pkg::coil_v_t'(omega_mag[17:5]);   // grows with speed

  // back emf eats into the drive in either direction
  assign raw_torque = (fav_v >= 0) ? fav_v - back_emf : fav_v + back_emf;

  always_comb begin
    if (raw_torque > motor_cfg_pkg::FRICTION)
      net_torque = raw_torque - motor_cfg_pkg::FRICTION;
    else if (raw_torque < -motor_cfg_pkg::FRICTION)
      net_torque = raw_torque + motor_cfg_pkg::FRICTION;
    else if (omega > motor_cfg_pkg::OMEGA_STICTION)
      net_torque = -motor_cfg_pkg::FRICTION;  // coasting forward so slow it
    else if (omega < -motor_cfg_pkg::OMEGA_STICTION)
      net_torque = motor_cfg_pkg::FRICTION;   // coasting backward
    else
      net_torque = '0;                        // stuck
  end

  assign alpha   = net_torque >>> 1;          // half the torque
  assign d_omega = {{9{alpha[12]}}, alpha[12:2]};

  ////////////////////////////////////////
  // velocity and position integration
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge RST_n) begin
    if (!RST_n)
      omega <= '0;
    else if (coil.vld)
      omega <= omega + d_omega;
  end

  // position moves by omega / 256 each window
  assign new_theta = $signed({1'b0, theta}) + $signed({{4{omega[19]}}, omega[19:8]});

  always_ff @(posedge clk or negedge RST_n) begin
    if (!RST_n)
      theta <= motor_cfg_pkg::THETA_RESET;
    else if (coil.vld) begin
      if (new_theta < 0)                                   // wrapped below zero
        theta <= new_theta[14:0] + motor_cfg_pkg::THETA_FULL;
      else if (new_theta >= motor_cfg_pkg::THETA_FULL)     // past a full turn
        theta <= new_theta[14:0] - motor_cfg_pkg::THETA_FULL;
      else
        theta <= new_theta[14:0];
    end
  end

  a_theta_range: assert property (@(posedge clk) disable iff (!RST_n)
    theta < motor_cfg_pkg::THETA_FULL)
    else $error("rotor_dynamics: position %0d beyond a full turn", theta);

  a_hall_legal: assert property (@(posedge clk) disable iff (!RST_n)
    !(hall_code inside {3'b000, 3'b111}))
    else $error("rotor_dynamics: illegal hall code %b", hall_code);

endmodule

/* source/current_estimator.sv */
module current_estimator (
  input  logic                        clk,
  input  logic                        RST_n,
  coil_volt_if.user                   coil,
  input  motor_types_pkg::omega_mag_t omega_mag,
  output motor_types_pkg::curr_t      avg_curr
);

  logic [12:0] abs_gy, abs_yb, abs_bg;     // coil magnitudes
  logic [13:0] sum_v;                      // room for three magnitudes
  logic [11:0] spd_factor;                 // 1.0 + speed, in 1/512 steps
  logic [25:0] curr_prod;
  logic [motor_cfg_pkg::CURR_ACC_W-1:0] curr_in;   // new sample for the filter
  logic [motor_cfg_pkg::CURR_ACC_W+motor_cfg_pkg::CURR_FILTER_SH-1:0] acc_prod;
  logic [motor_cfg_pkg::CURR_ACC_W-1:0] acc;

  assign abs_gy = coil.gy[12] ? 13'(-coil.gy) : 13'(coil.gy);
  assign abs_yb = coil.yb[12] ? 13'(-coil.yb) : 13'(coil.yb);
  assign abs_bg = coil.bg[12] ? 13'(-coil.bg) : 13'(coil.bg);
  assign sum_v  = {1'b0, abs_gy} + {1'b0, abs_yb} + {1'b0, abs_bg};

  // faster wheel draws more for the same drive
  assign spd_factor = motor_cfg_pkg::CURR_SPD_UNITY + {1'b0, omega_mag[18:8]};
  assign curr_prod  = sum_v * spd_factor;
  assign curr_in    = curr_prod[motor_cfg_pkg::CURR_ACC_W+motor_cfg_pkg::CURR_SPD_SH-1:
                                motor_cfg_pkg::CURR_SPD_SH];

  // 31/32 of the old value, divided out below
  assign acc_prod = {{motor_cfg_pkg::CURR_FILTER_SH{1'b0}}, acc} * motor_cfg_pkg::CURR_FILTER_K;

  always_ff @(posedge clk or negedge RST_n) begin
    if (!RST_n)
      acc <= '0;
    else if (coil.vld)
      acc <= acc_prod[$high(acc_prod):motor_cfg_pkg::CURR_FILTER_SH] + curr_in;
  end

  assign avg_curr = acc[motor_cfg_pkg::CURR_ACC_W-1:motor_cfg_pkg::CURR_FILTER_SH];

endmodule

/* source/hub_wheel_model.sv */
module hub_wheel_model (
  input  logic                   clk,
  input  logic                   RST_n,
  input  logic                   high_grn,   // green end gates
  input  logic                   low_grn,
  input  logic                   high_ylw,   // yellow end gates
  input  logic                   low_ylw,
  input  logic                   high_blu,   // blue end gates
  input  logic                   low_blu,
  output logic                   hall_grn,
  output logic                   hall_ylw,
  output logic                   hall_blu,
  output motor_types_pkg::curr_t avg_curr
);

  motor_types_pkg::omega_mag_t omega_mag;   // speed for the current estimate

  gate_duty_if duty_bus ();
  coil_volt_if coil_bus ();

  ////////////////////////////////////////
  // gate drive measurement
  ////////////////////////////////////////
  gate_duty_meter u_meter (
    .clk      (clk),
    .RST_n    (RST_n),
    .high_grn (high_grn),
    .low_grn  (low_grn),
    .high_ylw (high_ylw),
    .low_ylw  (low_ylw),
    .high_blu (high_blu),
    .low_blu  (low_blu),
    .duty     (duty_bus.meter)
  );

  coil_voltage_calc u_coil (
    .duty (duty_bus.user),
    .coil (coil_bus.calc)
  );

  ////////////////////////////////////////
  // mechanics and current
  ////////////////////////////////////////
  rotor_dynamics u_rotor (
    .clk       (clk),
    .RST_n     (RST_n),
    .coil      (coil_bus.user),
    .hall_grn  (hall_grn),
    .hall_ylw  (hall_ylw),
    .hall_blu  (hall_blu),
    .omega_mag (omega_mag)
  );

  current_estimator u_curr (
    .clk       (clk),
    .RST_n     (RST_n),
    .coil      (coil_bus.user),
    .omega_mag (omega_mag),
    .avg_curr  (avg_curr)
  );

endmodule

/* verification/hub_wheel_ref.svh */
`ifndef HUB_WHEEL_REF_SVH
`define HUB_WHEEL_REF_SVH

////////////////////////////////////////
// hall sequence
////////////////////////////////////////
// {grn, ylw, blu} codes in forward rotation order, green rise first
localparam logic [2:0] HALL_ORDER [6] = '{3'b101, 3'b100, 3'b110, 3'b010, 3'b011, 3'b001};

// position of a code in the forward order, -1 for an illegal code
function automatic int hall_index(input logic [2:0] code);
  hall_index = -1;
  for (int i = 0; i < 6; i++) begin
    if (HALL_ORDER[i] == code)
      hall_index = i;
  end
endfunction

function automatic logic [2:0] hall_after(input logic [2:0] code);
  int idx;
  idx = hall_index(code);
  hall_after = (idx < 0) ? 3'b000 : HALL_ORDER[(idx + 1) % 6];  // 000 never matches a legal code
endfunction

function automatic logic [2:0] hall_before(input logic [2:0] code);
  int idx;
  idx = hall_index(code);
  hall_before = (idx < 0) ? 3'b000 : HALL_ORDER[(idx + 5) % 6];
endfunction

////////////////////////////////////////
// first current estimate
////////////////////////////////////////
// filter starts at zero, so the first value is one sample scaled by 1/32
function automatic int first_curr(input int hg, lg, hy, ly, hb, lb, input int spd_top);
  int net_g, net_y, net_b;   // net drive per end
  bit flt_g, flt_y, flt_b;   // end floats
  int v_gy, v_yb, v_bg;
  int sum;
  net_g = hg - lg;
  net_y = hy - ly;
  net_b = hb - lb;
  flt_g = (hg < int'(motor_cfg_pkg::DUTY_DRIVEN)) && (lg < int'(motor_cfg_pkg::DUTY_DRIVEN));
  flt_y = (hy < int'(motor_cfg_pkg::DUTY_DRIVEN)) && (ly < int'(motor_cfg_pkg::DUTY_DRIVEN));
  flt_b = (hb < int'(motor_cfg_pkg::DUTY_DRIVEN)) && (lb < int'(motor_cfg_pkg::DUTY_DRIVEN));
  v_gy  = (flt_g || flt_y) ? 0 : net_g - net_y;
  v_yb  = (flt_y || flt_b) ? 0 : net_y - net_b;
  v_bg  = (flt_b || flt_g) ? 0 : net_b - net_g;
  sum   = (v_gy < 0 ? -v_gy : v_gy) + (v_yb < 0 ? -v_yb : v_yb) + (v_bg < 0 ? -v_bg : v_bg);
  sum   = sum * (512 + spd_top) / 512;  // speed scale
  first_curr = sum >> 5;
endfunction

`endif

/* verification/hub_wheel_model_tb.sv */
module hub_wheel_model_tb;
  timeunit 1ns;
  timeprecision 1ps;

  `include "hub_wheel_ref.svh"

  localparam int CLK_PERIOD  = 100;
  localparam int WINDOW      = 2 ** motor_cfg_pkg::PWM_W;  // clocks per pwm window
  localparam int FULL_DUTY   = WINDOW - 1;   // gate held on over every counted clock
  localparam int CYCLE_LIMIT = 1_200_000;    // about 585 windows where the phases take some 450

  typedef enum int {PH_IDLE, PH_COAST, PH_FIRST, PH_FWD, PH_SPIN, PH_REV} phase_e;
  typedef enum int {DRV_OFF, DRV_GY, DRV_FWD, DRV_REV} drive_e;

  logic                   clk;
  logic                   RST_n;
  logic [5:0]             gates;       // {hg, lg, hy, ly, hb, lb}
  logic                   hall_grn, hall_ylw, hall_blu;
  logic [2:0]             hall;
  motor_types_pkg::curr_t avg_curr;

  phase_e     phase;
  drive_e     drive;
  int         mismatch_cnt = 0;
  int         fail_cnt     = 0;
  int         hall_changes = 0;        // counted by the compare process
  bit         first_done   = 1'b0;
  logic [2:0] prev_hall;
  int         prev_curr;
  int         tick         = 0;        // compare process clock count
  int         last_change  = 0;
  int         last_gap     = 0;        // clocks between the last two hall changes

  assign hall = {hall_grn, hall_ylw, hall_blu};

  hub_wheel_model DUT (
    .clk      (clk),
    .RST_n    (RST_n),
    .high_grn (gates[5]),
    .low_grn  (gates[4]),
    .high_ylw (gates[3]),
    .low_ylw  (gates[2]),
    .high_blu (gates[1]),
    .low_blu  (gates[0]),
    .hall_grn (hall_grn),
    .hall_ylw (hall_ylw),
    .hall_blu (hall_blu),
    .avg_curr (avg_curr)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////
  // commutation
  ////////////////////////////////////////
  // drive the coil pair the sector favors with its positive end high
  function automatic logic [5:0] fwd_pattern(input logic [2:0] code);
    case (code)
      3'b101:  fwd_pattern = 6'b10_01_00;   // green high, yellow low
      3'b100:  fwd_pattern = 6'b10_00_01;   // green high, blue low
      3'b110:  fwd_pattern = 6'b00_10_01;   // yellow high, blue low
      3'b010:  fwd_pattern = 6'b01_10_00;   // yellow high, green low
      3'b011:  fwd_pattern = 6'b01_00_10;   // blue high, green low
      3'b001:  fwd_pattern = 6'b00_01_10;   // blue high, yellow low
      default: fwd_pattern = 6'b00_00_00;
    endcase
  endfunction

  // same ends with high and low swapped so the pair is driven the other way
  function automatic logic [5:0] rev_pattern(input logic [2:0] code);
    logic [5:0] p;
    p = fwd_pattern(code);
    rev_pattern = {p[4], p[5], p[2], p[3], p[0], p[1]};
  endfunction

  always @(negedge clk) begin
    case (drive)
      DRV_GY:  gates = 6'b10_01_00;         // static green to yellow
      DRV_FWD: gates = fwd_pattern(hall);
      DRV_REV: gates = rev_pattern(hall);
      default: gates = 6'b00_00_00;
    endcase
  end

  ////////////////////////////////////////
  // compare process
  ////////////////////////////////////////
  always @(posedge clk) begin : compare
    int interval;
    int exp_curr;
    tick++;
    if (!RST_n) begin
      prev_hall   = hall;
      prev_curr   = avg_curr;
      last_change = tick;
    end else begin
      if (hall_index(hall) < 0) begin
        $display("ERROR: hall outputs read %b, not one of the six sector codes", hall);
        fail_cnt++;
      end
      interval = tick - last_change;
      case (phase)
        PH_COAST: begin
          if (hall != prev_hall) begin
            $display("MISMATCH coast_hall expected %b actual %b", prev_hall, hall);
            mismatch_cnt++;
          end
          if (avg_curr != prev_curr) begin
            $display("MISMATCH coast_curr expected %0d actual %0d", prev_curr, avg_curr);
            mismatch_cnt++;
          end
        end
        PH_FIRST: begin
          if (!first_done && avg_curr != prev_curr) begin
            exp_curr = first_curr(FULL_DUTY, 0, 0, FULL_DUTY, 0, 0, 0);
            if (avg_curr != exp_curr) begin
              $display("MISMATCH first_curr expected %0d actual %0d", exp_curr, avg_curr);
              mismatch_cnt++;
            end
            first_done = 1'b1;
          end
        end
        PH_FWD, PH_SPIN: begin
          if (hall != prev_hall) begin
            hall_changes++;
            if (hall != hall_after(prev_hall)) begin
              $display("MISMATCH forward_hall expected %b actual %b", hall_after(prev_hall), hall);
              mismatch_cnt++;
            end
            // rotor only slows while coasting, so sectors take no less time
            if (phase == PH_SPIN && hall_changes >= 3 && interval + WINDOW < last_gap) begin
              $display("ERROR: hall changes came faster during spin-down (%0d after %0d clocks)",
                       interval, last_gap);
              fail_cnt++;
            end
            last_gap = interval;
          end
          if (phase == PH_SPIN && avg_curr > prev_curr) begin
            $display("MISMATCH spin_down_curr expected < %0d actual %0d", prev_curr, avg_curr);
            mismatch_cnt++;
          end
        end
        PH_REV: begin
          if (hall != prev_hall) begin
            hall_changes++;
            if (hall != hall_before(prev_hall)) begin
              $display("MISMATCH reverse_hall expected %b actual %b", hall_before(prev_hall), hall);
              mismatch_cnt++;
            end
          end
        end
        default: ;
      endcase
      if (hall != prev_hall)
        last_change = tick;
      prev_hall = hall;
      prev_curr = avg_curr;
    end
  end

  ////////////////////////////////////////
  // run control
  ////////////////////////////////////////
  task automatic finish_run();
    $display("checks done: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  endtask

  task automatic apply_reset();
    @(negedge clk);
    RST_n = 1'b0;
    repeat (8) @(negedge clk);
    RST_n = 1'b1;
  endtask

  // mode changes on the rising edge and the driver picks it up on the next falling one
  task automatic set_drive(input drive_e mode);
    @(posedge clk);
    drive = mode;
  endtask

  task automatic wait_windows(input int n);
    repeat (n * WINDOW) @(negedge clk);
  endtask

  initial begin : watchdog
    int cycle_cnt;
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("ERROR: run did not finish within %0d clock cycles", CYCLE_LIMIT);
    fail_cnt++;
    finish_run();
  end

  initial begin : main
    int spin_len;
    RST_n = 1'b0;
    gates = 6'b0;
    drive = DRV_OFF;
    phase = PH_IDLE;
    void'($urandom(32'hb1b3));   // seeds the run

    // reset state, then a coast with every gate off
    apply_reset();
    if (hall != 3'b101) begin
      $display("MISMATCH reset_hall expected %b actual %b", 3'b101, hall);
      mismatch_cnt++;
    end
    if (avg_curr != 0) begin
      $display("MISMATCH reset_curr expected %0d actual %0d", 0, avg_curr);
      mismatch_cnt++;
    end
    phase = PH_COAST;
    wait_windows(10);
    phase = PH_IDLE;

    // green high and yellow low held on from reset
    set_drive(DRV_GY);
    apply_reset();
    phase = PH_FIRST;
    wait (first_done);
    @(negedge clk);
    phase = PH_IDLE;

    // forward commutation from rest
    set_drive(DRV_FWD);
    apply_reset();
    hall_changes = 0;
    phase = PH_FWD;
    wait (hall_changes >= 12);
    @(negedge clk);

    // drive off and let the last driven window pass before checking the coast
    phase = PH_IDLE;
    set_drive(DRV_OFF);
    wait_windows(2);
    spin_len = 30 + ($urandom % 31);
    hall_changes = 0;
    phase = PH_SPIN;
    wait_windows(spin_len);
    phase = PH_IDLE;

    // reverse commutation from rest
    set_drive(DRV_REV);
    apply_reset();
    hall_changes = 0;
    phase = PH_REV;
    wait (hall_changes >= 3);
    @(negedge clk);
    wait_windows($urandom % 8);
    phase = PH_IDLE;

    finish_run();
  end

endmodule

/* hub_wheel_model.f */
+incdir+verification
source/motor_cfg_pkg.sv
source/motor_types_pkg.sv
source/gate_duty_if.sv
source/coil_volt_if.sv
source/gate_duty_meter.sv
source/coil_voltage_calc.sv
source/rotor_dynamics.sv
source/current_estimator.sv
source/hub_wheel_model.sv
verification/hub_wheel_model_tb.sv

/* Bender.yml */
package:
  name: hub_wheel_model

sources:
  - files:
      - source/motor_cfg_pkg.sv
      - source/motor_types_pkg.sv
      - source/gate_duty_if.sv
      - source/coil_volt_if.sv
      - source/gate_duty_meter.sv
      - source/coil_voltage_calc.sv
      - source/rotor_dynamics.sv
      - source/current_estimator.sv
      - source/hub_wheel_model.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/hub_wheel_model_tb.sv
